// File: include/endpoint_defines.svh
`ifndef ENDPOINT_DEFINES_SVH
`define ENDPOINT_DEFINES_SVH

`define NUM_MSGS 4
`define CACHE_NUM_WORDS 128
`define CACHE_ADDR_W 9
`define REQ_FIFO_DEPTH 4

// Host address map
`define PKT_ID_BASE 32'h0000
`define TX_SEND_ADDR 32'h1004
`define STATUS_ADDR 32'h1008
`define TX_CACHE_BASE 32'h2000
`define RX_CACHE_BASE 32'h3000
`define REQ_FIFO_ADDR 32'h3400

// Header word fields
`define HDR_FMT_MSB 31
`define HDR_FMT_LSB 28
`define HDR_DEST_MSB 27
`define HDR_DEST_LSB 24
`define HDR_SRC_MSB 23
`define HDR_SRC_LSB 20
`define HDR_LEN_MSB 6
`define HDR_LEN_LSB 0

`endif

// File: rtl/chiplet_types_pkg.sv
package chiplet_types_pkg;
    typedef enum logic [3:0] {
        FMT_IDLE = 4'h0,
        FMT_MSG  = 4'h1,
        FMT_RESP = 4'h2
    } pkt_fmt_e;

    typedef struct packed {
        pkt_fmt_e    fmt;
        logic [3:0]  dest_id;
        logic [3:0]  src_id;
        logic [12:0] reserved;
        logic [6:0]  len;         // Payload words, header and check word not counted
    } pkt_header_t;

    typedef struct packed {
        logic [3:0] src_id;
        logic [6:0] len;
        logic [6:0] start_word;   // Word index of the first payload word in the receive cache
    } req_entry_t;
endpackage

// File: rtl/endpoint_ctrl_pkg.sv
package endpoint_ctrl_pkg;
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HEADER,
        TX_PAYLOAD,
        TX_CHECK
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PAYLOAD,
        RX_CHECK,
        RX_DROP
    } rx_state_e;
endpackage

// File: rtl/word_cache.sv
`timescale 1ns/1ps
`include "endpoint_defines.svh"

module word_cache (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     wen,
    input  logic                     ren,
    input  logic [`CACHE_ADDR_W-1:0] addr,
    input  logic [31:0]              wdata,
    input  logic [3:0]               strobe,
    output logic [31:0]              rdata
);
    logic [31:0] mem [`CACHE_NUM_WORDS];
    logic [`CACHE_ADDR_W-3:0] word_idx;

    assign word_idx = addr[`CACHE_ADDR_W-1:2];
    assign rdata = ren ? mem[word_idx] : '0;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < `CACHE_NUM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            for (int b = 0; b < 4; b++) begin
                if (strobe[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata[8*b +: 8]; // Only the strobed bytes change
                end
            end
        end
    end
endmodule

// File: rtl/msg_table.sv
`timescale 1ns/1ps
`include "endpoint_defines.svh"

module msg_table (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        cfg_wen,
    input  logic                        cfg_ren,
    input  logic [$clog2(`NUM_MSGS)-1:0] cfg_index,
    input  logic [31:0]                 cfg_wdata,
    output logic [31:0]                 cfg_rdata,
    input  logic [`NUM_MSGS-1:0]        trigger,
    input  logic                        take,
    output logic [$clog2(`NUM_MSGS)-1:0] sel_index,
    output logic                        sel_valid,
    output logic [`CACHE_ADDR_W-1:0]    sel_start_addr
);
    logic [`CACHE_ADDR_W-1:0] start_addr [`NUM_MSGS];
    logic [`NUM_MSGS-1:0] pending;

    assign cfg_rdata = cfg_ren ? 32'(start_addr[cfg_index]) : '0;
    assign sel_start_addr = start_addr[sel_index];

    // Lowest pending index wins
    always_comb begin
        sel_index = '0;
        sel_valid = 1'b0;
        for (int i = `NUM_MSGS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel_index = i[$clog2(`NUM_MSGS)-1:0];
                sel_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pending <= '0;
            for (int i = 0; i < `NUM_MSGS; i++) begin
                start_addr[i] <= '0;
            end
        end else begin
            if (take) begin
                pending <= (pending & ~(`NUM_MSGS'(1) << sel_index)) | trigger;
            end else begin
                pending <= pending | trigger;
            end
            if (cfg_wen) begin
                start_addr[cfg_index] <= {cfg_wdata[`CACHE_ADDR_W-1:2], 2'b00}; // Word aligned
            end
        end
    end
endmodule

// File: rtl/tx_engine.sv
`timescale 1ns/1ps
`include "endpoint_defines.svh"

module tx_engine
    import chiplet_types_pkg::*, endpoint_ctrl_pkg::*;
#(
    parameter logic [3:0] NODE_ID = 4'd0
) (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     sel_valid,
    input  logic [`CACHE_ADDR_W-1:0] sel_start_addr,
    output logic                     take,
    output logic                     cache_ren,
    output logic [`CACHE_ADDR_W-1:0] cache_addr,
    input  logic [31:0]              cache_rdata,
    output logic [31:0]              tx_data,
    output logic                     tx_valid,
    input  logic                     tx_busy
);
    tx_state_e state;
    logic [`CACHE_ADDR_W-3:0] rd_ptr;
    logic [6:0] remaining;
    logic [31:0] chk;
    logic advance;
    pkt_header_t hdr;

    assign advance = !(tx_valid && tx_busy); // The switch holds the current flit while busy
    assign take = (state == TX_IDLE) && sel_valid;
    assign cache_ren = advance && (state == TX_HEADER || state == TX_PAYLOAD);
    assign cache_addr = {rd_ptr, 2'b00};

    always_comb begin
        hdr = pkt_header_t'(cache_rdata);
        hdr.src_id = NODE_ID;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state     <= TX_IDLE;
            rd_ptr    <= '0;
            remaining <= '0;
            chk       <= '0;
            tx_data   <= '0;
            tx_valid  <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (advance) begin
                        tx_valid <= 1'b0;
                    end
                    if (sel_valid) begin
                        rd_ptr <= sel_start_addr[`CACHE_ADDR_W-1:2];
                        state  <= TX_HEADER;
                    end
                end
                TX_HEADER: begin
                    if (advance) begin
                        tx_data   <= hdr;
                        tx_valid  <= 1'b1;
                        chk       <= hdr;  // Check covers the header as sent
                        remaining <= hdr.len;
                        rd_ptr    <= rd_ptr + 1'b1;
                        state     <= (hdr.len == '0) ? TX_CHECK : TX_PAYLOAD;
                    end
                end
                TX_PAYLOAD: begin
                    if (advance) begin
                        tx_data   <= cache_rdata;
                        chk       <= chk ^ cache_rdata;
                        rd_ptr    <= rd_ptr + 1'b1; // Wraps at the cache end
                        remaining <= remaining - 1'b1;
                        if (remaining == 7'd1) begin
                            state <= TX_CHECK;
                        end
                    end
                end
                TX_CHECK: begin
                    if (advance) begin
                        tx_data <= chk;
                        state   <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end
endmodule

// File: rtl/rx_engine.sv
`timescale 1ns/1ps
`include "endpoint_defines.svh"

module rx_engine
    import chiplet_types_pkg::*, endpoint_ctrl_pkg::*;
#(
    parameter logic [3:0] NODE_ID = 4'd0
) (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic [31:0]              rx_data,
    input  logic                     rx_valid,
    output logic                     cache_wen,
    output logic [`CACHE_ADDR_W-1:0] cache_addr,
    output logic [31:0]              cache_wdata,
    output req_entry_t               entry,
    output logic                     entry_push,
    output logic                     check_fail
);
    rx_state_e state;
    logic [6:0] wr_ptr;
    logic [6:0] pkt_start;
    logic [6:0] remaining;
    logic [31:0] chk;
    logic [3:0] src_id;
    logic [6:0] len;
    logic accept;

    assign accept = pkt_fmt_e'(rx_data[`HDR_FMT_MSB:`HDR_FMT_LSB]) == FMT_MSG &&
                    rx_data[`HDR_DEST_MSB:`HDR_DEST_LSB] == NODE_ID;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state       <= RX_IDLE;
            wr_ptr      <= '0;
            pkt_start   <= '0;
            remaining   <= '0;
            chk         <= '0;
            src_id      <= '0;
            len         <= '0;
            cache_wen   <= 1'b0;
            cache_addr  <= '0;
            cache_wdata <= '0;
            entry       <= '0;
            entry_push  <= 1'b0;
            check_fail  <= 1'b0;
        end else begin
            cache_wen  <= 1'b0;
            entry_push <= 1'b0;
            check_fail <= 1'b0;
            if (rx_valid) begin
                case (state)
                    RX_IDLE: begin
                        remaining <= rx_data[`HDR_LEN_MSB:`HDR_LEN_LSB];
                        if (accept) begin
                            chk       <= rx_data;
                            src_id    <= rx_data[`HDR_SRC_MSB:`HDR_SRC_LSB];
                            len       <= rx_data[`HDR_LEN_MSB:`HDR_LEN_LSB];
                            pkt_start <= wr_ptr;
                            state     <= (rx_data[`HDR_LEN_MSB:`HDR_LEN_LSB] == '0) ?
                                         RX_CHECK : RX_PAYLOAD;
                        end else begin
                            state <= RX_DROP;  // Skips len payload words plus the check word
                        end
                    end
                    RX_PAYLOAD: begin
                        cache_wen   <= 1'b1;
                        cache_addr  <= {wr_ptr, 2'b00};
                        cache_wdata <= rx_data;
                        chk         <= chk ^ rx_data;
                        wr_ptr      <= wr_ptr + 1'b1;
                        remaining   <= remaining - 1'b1;
                        if (remaining == 7'd1) begin
                            state <= RX_CHECK;
                        end
                    end
                    RX_CHECK: begin
                        if (rx_data == chk) begin
                            entry      <= '{src_id: src_id, len: len, start_word: pkt_start};
                            entry_push <= 1'b1;
                        end else begin
                            check_fail <= 1'b1;
                            wr_ptr     <= pkt_start; // Next packet overwrites the bad one
                        end
                        state <= RX_IDLE;
                    end
                    RX_DROP: begin
                        if (remaining == '0) begin
                            state <= RX_IDLE;
                        end else begin
                            remaining <= remaining - 1'b1;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end
endmodule

// File: rtl/req_fifo.sv
`timescale 1ns/1ps
`include "endpoint_defines.svh"

module req_fifo
    import chiplet_types_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  n_rst,
    input  logic                                  push,
    input  req_entry_t                            entry,
    input  logic                                  pop,
    output req_entry_t                            head,
    output logic                                  empty,
    output logic [$clog2(`REQ_FIFO_DEPTH+1)-1:0] count,
    output logic                                  overflow
);
    localparam int PTR_W = $clog2(`REQ_FIFO_DEPTH);

    req_entry_t buffer [`REQ_FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr, wr_ptr;
    logic full, do_push, do_pop;

    assign empty = (count == '0);
    assign full = (count == `REQ_FIFO_DEPTH);
    assign do_push = push && !full;
    assign do_pop = pop && !empty;
    assign head = buffer[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            buffer[wr_ptr] <= entry;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push && full) begin
                overflow <= 1'b1; // Entry is lost, flag stays until reset
            end
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
        end
    end
endmodule

// File: rtl/endpoint.sv
`timescale 1ns/1ps
`include "endpoint_defines.svh"

module endpoint
    import chiplet_types_pkg::*;
#(
    parameter logic [3:0] NODE_ID = 4'd0
) (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        ren,
    input  logic        wen,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  strobe,
    output logic [31:0] rdata,
    output logic        error,
    output logic        request_stall,
    output logic [31:0] tx_data,
    output logic        tx_valid,
    input  logic        tx_busy,
    input  logic [31:0] rx_data,
    input  logic        rx_valid
);
    localparam int IDX_W = $clog2(`NUM_MSGS);
    localparam int CACHE_BYTES = 4 * `CACHE_NUM_WORDS;

    logic in_msg_win, in_tx_win, in_rx_win;
    logic cfg_wen, cfg_ren;
    logic [31:0] cfg_rdata;
    logic [`NUM_MSGS-1:0] trigger;
    logic take, sel_valid;
    logic [`CACHE_ADDR_W-1:0] sel_start_addr;

    logic eng_ren, host_tx_ren, host_tx_wen;
    logic [`CACHE_ADDR_W-1:0] eng_addr, tx_cache_addr;
    logic [31:0] tx_cache_rdata;

    logic host_rx_ren, rx_wen;
    logic [`CACHE_ADDR_W-1:0] rx_eng_addr, rx_cache_addr;
    logic [31:0] rx_wdata, rx_cache_rdata;

    req_entry_t rx_entry, fifo_head;
    logic entry_push, check_fail, fifo_pop, fifo_empty, fifo_overflow;
    logic [$clog2(`REQ_FIFO_DEPTH+1)-1:0] fifo_count;
    logic [7:0] fail_cnt;
    logic [31:0] status;

    // Window checks rely on unsigned wrap below each base
    assign in_msg_win = (addr - `PKT_ID_BASE) < 4 * `NUM_MSGS;
    assign in_tx_win = (addr - `TX_CACHE_BASE) < CACHE_BYTES;
    assign in_rx_win = (addr - `RX_CACHE_BASE) < CACHE_BYTES;

    // The engine owns the transmit cache whenever it reads
    assign tx_cache_addr = eng_ren ? eng_addr : addr[`CACHE_ADDR_W-1:0];
    assign rx_cache_addr = rx_wen ? rx_eng_addr : addr[`CACHE_ADDR_W-1:0];

    always_comb begin
        status = '0;
        status[0] = fifo_overflow;
        status[15:8] = fail_cnt;
        status[19:16] = 4'(fifo_count);
    end

    always_comb begin
        rdata = '0;
        error = 1'b0;
        request_stall = 1'b0;
        cfg_wen = 1'b0;
        cfg_ren = 1'b0;
        trigger = '0;
        host_tx_ren = 1'b0;
        host_tx_wen = 1'b0;
        host_rx_ren = 1'b0;
        fifo_pop = 1'b0;
        if (ren || wen) begin
            if (in_msg_win) begin
                cfg_wen = wen;
                cfg_ren = ren;
                rdata = cfg_rdata;
            end else if (addr == `TX_SEND_ADDR && wen) begin
                if (wdata < `NUM_MSGS) begin
                    trigger[wdata[IDX_W-1:0]] = 1'b1;
                end else begin
                    error = 1'b1;
                end
            end else if (addr == `STATUS_ADDR && ren) begin
                rdata = status;
            end else if (in_tx_win) begin
                if (eng_ren) begin
                    request_stall = 1'b1;
                end else begin
                    host_tx_ren = ren;
                    host_tx_wen = wen;
                    rdata = tx_cache_rdata;
                end
            end else if (in_rx_win && ren) begin
                if (rx_wen) begin
                    request_stall = 1'b1; // Single address port is busy with a payload write
                end else begin
                    host_rx_ren = 1'b1;
                    rdata = rx_cache_rdata;
                end
            end else if (addr == `REQ_FIFO_ADDR && ren) begin
                if (fifo_empty) begin
                    error = 1'b1;
                end else begin
                    fifo_pop = 1'b1;
                    rdata = 32'(fifo_head);
                end
            end else begin
                error = 1'b1;
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            fail_cnt <= '0;
        end else if (check_fail && fail_cnt != 8'hFF) begin
            fail_cnt <= fail_cnt + 1'b1;
        end
    end

    msg_table msg_table0 (
        .clk(clk), .n_rst(n_rst),
        .cfg_wen(cfg_wen), .cfg_ren(cfg_ren), .cfg_index(addr[2 +: IDX_W]),
        .cfg_wdata(wdata), .cfg_rdata(cfg_rdata), .trigger(trigger), .take(take),
        .sel_index(), .sel_valid(sel_valid), .sel_start_addr(sel_start_addr)
    );

    word_cache tx_cache (
        .clk(clk), .n_rst(n_rst), .wen(host_tx_wen), .ren(eng_ren || host_tx_ren),
        .addr(tx_cache_addr), .wdata(wdata), .strobe(strobe), .rdata(tx_cache_rdata)
    );

    tx_engine #(.NODE_ID(NODE_ID)) tx_engine0 (
        .clk(clk), .n_rst(n_rst), .sel_valid(sel_valid), .sel_start_addr(sel_start_addr),
        .take(take), .cache_ren(eng_ren), .cache_addr(eng_addr),
        .cache_rdata(tx_cache_rdata), .tx_data(tx_data), .tx_valid(tx_valid),
        .tx_busy(tx_busy)
    );

    rx_engine #(.NODE_ID(NODE_ID)) rx_engine0 (
        .clk(clk), .n_rst(n_rst), .rx_data(rx_data), .rx_valid(rx_valid),
        .cache_wen(rx_wen), .cache_addr(rx_eng_addr), .cache_wdata(rx_wdata),
        .entry(rx_entry), .entry_push(entry_push), .check_fail(check_fail)
    );

    word_cache rx_cache (
        .clk(clk), .n_rst(n_rst), .wen(rx_wen), .ren(host_rx_ren),
        .addr(rx_cache_addr), .wdata(rx_wdata), .strobe(4'hF), .rdata(rx_cache_rdata)
    );

    req_fifo req_fifo0 (
        .clk(clk), .n_rst(n_rst), .push(entry_push), .entry(rx_entry), .pop(fifo_pop),
        .head(fifo_head), .empty(fifo_empty), .count(fifo_count), .overflow(fifo_overflow)
    );
endmodule

// File: test/endpoint_tb.sv
`timescale 1ns/1ps
`include "endpoint_defines.svh"

module endpoint_tb
    import chiplet_types_pkg::*, endpoint_ctrl_pkg::*;
();
    localparam logic [3:0] NODE = 4'd3;

    typedef enum {K_WRITE, K_READ, K_POP, K_RX, K_TX} step_kind_e;

    typedef struct {
        step_kind_e  kind;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        logic        err;
    } step_t;

    logic clk = 1'b0;
    logic n_rst, ren, wen, tx_busy, rx_valid;
    logic [31:0] addr, wdata, rx_data;
    logic [3:0] strobe;
    logic [31:0] rdata, tx_data;
    logic error, request_stall, tx_valid;

    step_t steps[$];
    logic [31:0] rx_words[$];
    logic [31:0] exp_flits[$];
    logic [31:0] cap[$];
    logic [31:0] tx_model [`CACHE_NUM_WORDS];
    int msg_start [`NUM_MSGS];
    logic [6:0] rx_ptr;        // Where the next good packet lands in the receive cache
    req_entry_t fifo_model[$];
    logic ovf_model;
    int fails_model;
    int word_errs, hdr_errs, entry_errs, err_errs, other_errs;
    int stall_count, cycles, limit;

    endpoint #(.NODE_ID(NODE)) dut0 (
        .clk(clk), .n_rst(n_rst), .ren(ren), .wen(wen), .addr(addr), .wdata(wdata),
        .strobe(strobe), .rdata(rdata), .error(error), .request_stall(request_stall),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_busy(tx_busy),
        .rx_data(rx_data), .rx_valid(rx_valid)
    );

    always #5 clk = ~clk;

    // Switch side: a flit is taken on each edge where it is valid and the switch is free
    always @(posedge clk) begin
        if (n_rst && tx_valid && !tx_busy) begin
            cap.push_back(tx_data);
        end
        tx_busy <= n_rst ? 1'($urandom_range(0, 1)) : 1'b0;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_word(input string msg, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
            word_errs++;
        end
    endtask

    task automatic check_header(input string msg, input pkt_header_t got,
                                input pkt_header_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s header got %h expected %h", $time, msg, got, exp);
            hdr_errs++;
        end
    endtask

    task automatic check_entry(input string msg, input req_entry_t got, input req_entry_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s entry got src %h len %0d start %0d, expected %h %0d %0d",
                     $time, msg, got.src_id, got.len, got.start_word,
                     exp.src_id, exp.len, exp.start_word);
            entry_errs++;
        end
    endtask

    task automatic check_error(input string msg, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s error bit got %b expected %b", $time, msg, got, exp);
            err_errs++;
        end
    endtask

    task automatic add_step(input step_kind_e kind, input logic [31:0] a, input logic [31:0] d,
                            input logic [31:0] e, input logic err);
        steps.push_back('{kind: kind, a: a, d: d, e: e, err: err});
    endtask

    task automatic host_write(input logic [31:0] a, input logic [31:0] d, input logic err);
        add_step(K_WRITE, a, d, 32'h0, err);
        if (a >= `TX_CACHE_BASE && a < `TX_CACHE_BASE + 4 * `CACHE_NUM_WORDS) begin
            tx_model[(a - `TX_CACHE_BASE) >> 2] = d;
        end
    endtask

    task automatic load_msg(input int m, input int s, input int len);
        pkt_header_t h;
        h = '0;
        h.fmt = FMT_MSG;
        h.dest_id = 4'h5;
        h.src_id = 4'hA;
        h.len = 7'(len);
        host_write(`TX_CACHE_BASE + 4 * s, h, 1'b0);
        for (int i = 0; i < len; i++) begin
            host_write(`TX_CACHE_BASE + 4 * ((s + 1 + i) % `CACHE_NUM_WORDS), $urandom, 1'b0);
        end
        host_write(`PKT_ID_BASE + 4 * m, 4 * s + m % 4, 1'b0); // Junk in the low bits
        add_step(K_READ, `PKT_ID_BASE + 4 * m, 32'h0, 4 * s, 1'b0);
        msg_start[m] = s;
    endtask

    task automatic expect_tx(input int m);
        pkt_header_t h;
        logic [31:0] w, chk;
        int s, off;
        s = msg_start[m];
        off = exp_flits.size();
        h = pkt_header_t'(tx_model[s]);
        h.src_id = NODE;
        exp_flits.push_back(h);
        chk = h;
        for (int i = 0; i < h.len; i++) begin
            w = tx_model[(s + 1 + i) % `CACHE_NUM_WORDS];
            exp_flits.push_back(w);
            chk ^= w;
        end
        exp_flits.push_back(chk);
        add_step(K_TX, off, h.len + 2, 32'h0, 1'b0);
    endtask

    task automatic rx_packet(input pkt_fmt_e fmt, input logic [3:0] dest, input logic [3:0] src,
                             input int len, input logic corrupt);
        pkt_header_t h;
        logic [31:0] chk, w;
        int off;
        off = rx_words.size();
        h = '0;
        h.fmt = fmt;
        h.dest_id = dest;
        h.src_id = src;
        h.len = 7'(len);
        rx_words.push_back(h);
        chk = h;
        for (int i = 0; i < len; i++) begin
            w = $urandom;
            rx_words.push_back(w);
            chk ^= w;
        end
        rx_words.push_back(corrupt ? chk ^ 32'h1 : chk);
        add_step(K_RX, off, len + 2, 32'h0, 1'b0);
        if (fmt == FMT_MSG && dest == NODE) begin
            if (corrupt) begin
                fails_model++;
            end else begin
                for (int i = 0; i < len; i++) begin
                    add_step(K_READ, `RX_CACHE_BASE + 4 * (7'(rx_ptr + i)), 32'h0,
                             rx_words[off + 1 + i], 1'b0);
                end
                if (fifo_model.size() < `REQ_FIFO_DEPTH) begin
                    fifo_model.push_back('{src_id: src, len: 7'(len), start_word: rx_ptr});
                end else begin
                    ovf_model = 1'b1;
                end
                rx_ptr = rx_ptr + 7'(len);
            end
        end
    endtask

    task automatic expect_status();
        logic [31:0] e;
        e = '0;
        e[0] = ovf_model;
        e[15:8] = 8'(fails_model);
        e[19:16] = 4'(fifo_model.size());
        add_step(K_READ, `STATUS_ADDR, 32'h0, e, 1'b0);
    endtask

    task automatic pop_entry();
        if (fifo_model.size() == 0) begin
            add_step(K_POP, `REQ_FIFO_ADDR, 32'h0, 32'h0, 1'b1);
        end else begin
            add_step(K_POP, `REQ_FIFO_ADDR, 32'h0, 32'(fifo_model.pop_front()), 1'b0);
        end
    endtask

    task automatic build_table();
        for (int i = 0; i < `CACHE_NUM_WORDS; i++) begin
            tx_model[i] = '0;
        end
        rx_ptr = '0;
        ovf_model = 1'b0;
        fails_model = 0;
        host_write(`TX_SEND_ADDR, `NUM_MSGS, 1'b1);
        host_write(32'h5000, 32'h1, 1'b1);
        add_step(K_READ, 32'h5000, 32'h0, 32'h0, 1'b1);
        pop_entry();
        load_msg(0, 16, 3);
        load_msg(1, 32, 2);
        load_msg(2, 64, 8);
        load_msg(3, 124, 6);   // Payload wraps past the cache end
        host_write(`TX_SEND_ADDR, 0, 1'b0);
        expect_tx(0);
        host_write(`TX_SEND_ADDR, 3, 1'b0);
        expect_tx(3);
        host_write(`TX_SEND_ADDR, 2, 1'b0);
        host_write(`TX_SEND_ADDR, 1, 1'b0);
        host_write(`TX_SEND_ADDR, 0, 1'b0);
        expect_tx(2);
        expect_tx(0);
        expect_tx(1);
        host_write(`TX_SEND_ADDR, 2, 1'b0);
        for (int i = 0; i < 4; i++) begin
            add_step(K_READ, `TX_CACHE_BASE + 4 * (64 + i), 32'h0, tx_model[64 + i], 1'b0);
        end
        expect_tx(2);
        rx_packet(FMT_MSG, NODE, 4'h7, 3, 1'b0);
        pop_entry();
        rx_packet(FMT_MSG, NODE, 4'h6, 2, 1'b1);
        expect_status();
        rx_packet(FMT_MSG, NODE, 4'h9, 2, 1'b0);
        pop_entry();
        rx_packet(FMT_MSG, 4'h4, 4'h2, 2, 1'b0);
        rx_packet(FMT_RESP, NODE, 4'h2, 1, 1'b0);
        expect_status();
        pop_entry();
        for (int i = 0; i < 5; i++) begin
            rx_packet(FMT_MSG, NODE, 4'(i + 1), 1, 1'b0);
        end
        expect_status();
        for (int i = 0; i < 5; i++) begin
            pop_entry();
        end
        expect_status();
    endtask

    task automatic bus_access(input logic is_write, input logic [31:0] a, input logic [31:0] d,
                              output logic [31:0] rd, output logic err);
        @(posedge clk);
        ren <= !is_write;
        wen <= is_write;
        addr <= a;
        wdata <= d;
        strobe <= 4'hF;
        @(negedge clk);
        while (request_stall) begin
            stall_count++;
            @(negedge clk);
        end
        rd = rdata;
        err = error;
        @(posedge clk);
        ren <= 1'b0;
        wen <= 1'b0;
    endtask

    task automatic run_step(input step_t s, input int n);
        logic [31:0] rd, got;
        logic err;
        string msg;
        msg = $sformatf("step %0d addr %h", n, s.a);
        case (s.kind)
            K_WRITE: begin
                bus_access(1'b1, s.a, s.d, rd, err);
                check_error(msg, err, s.err);
            end
            K_READ: begin
                bus_access(1'b0, s.a, 32'h0, rd, err);
                check_error(msg, err, s.err);
                if (!s.err) begin
                    check_word(msg, rd, s.e);
                end
            end
            K_POP: begin
                bus_access(1'b0, s.a, 32'h0, rd, err);
                check_error(msg, err, s.err);
                if (!s.err) begin
                    check_entry(msg, req_entry_t'(rd[17:0]), req_entry_t'(s.e[17:0]));
                    check_word({msg, " upper bits"}, {rd[31:18], 18'h0}, 32'h0);
                end
            end
            K_RX: begin
                for (int j = 0; j < s.d; j++) begin
                    @(posedge clk);
                    rx_valid <= 1'b1;
                    rx_data <= rx_words[s.a + j];
                end
                @(posedge clk);
                rx_valid <= 1'b0;
                repeat (3) @(posedge clk); // Entry posts two edges after the check word
            end
            K_TX: begin
                while (cap.size() < s.d) begin
                    @(posedge clk);
                end
                got = cap.pop_front();
                check_header(msg, pkt_header_t'(got), pkt_header_t'(exp_flits[s.a]));
                for (int j = 1; j < s.d; j++) begin
                    got = cap.pop_front();
                    check_word($sformatf("%s flit %0d", msg, j), got, exp_flits[s.a + j]);
                end
            end
        endcase
    endtask

    initial begin
        void'($urandom(65801));
        n_rst = 1'b0;
        ren = 1'b0;
        wen = 1'b0;
        addr = '0;
        wdata = '0;
        strobe = '0;
        rx_data = '0;
        rx_valid = 1'b0;
        tx_busy = 1'b0;
        build_table();
        limit = steps.size() * 64;
        repeat (2) @(posedge clk);
        n_rst <= 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            run_step(steps[i], i);
        end
        repeat (5) @(posedge clk);
        if (cap.size() != 0) begin
            $display("The switch received %0d flits that no packet accounts for", cap.size());
            other_errs++;
        end
        if (stall_count == 0) begin
            $display("No host access to the transmit cache was ever stalled by a transmission");
            other_errs++;
        end
        $display("errors: word %0d header %0d entry %0d error-bit %0d other %0d",
                 word_errs, hdr_errs, entry_errs, err_errs, other_errs);
        if (word_errs + hdr_errs + entry_errs + err_errs + other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end
endmodule

// File: all.f
+incdir+include
rtl/chiplet_types_pkg.sv
rtl/endpoint_ctrl_pkg.sv
rtl/word_cache.sv
rtl/msg_table.sv
rtl/tx_engine.sv
rtl/rx_engine.sv
rtl/req_fifo.sv
rtl/endpoint.sv
test/endpoint_tb.sv
